//--- rtl/mem_stage_pkg.sv
`default_nettype none

// Types seen by the pipeline on both sides of the memory stage.
package mem_stage_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [3:0]  size_t;    // Access size in bytes.

    // Legal access sizes.
    localparam size_t SIZE_BYTE = 4'd1;
    localparam size_t SIZE_HALF = 4'd2;
    localparam size_t SIZE_WORD = 4'd4;

    // Memory micro-op of one execute lane.
    typedef struct packed {
        addr_t mem_addr;
        logic  is_unsigned;   // Zero-extend loads.
        logic  mem_we;
        logic  mem_rd;
        size_t bit_width;
        word_t wdata;
        pc_t   pc;
    } es_to_ms_t;

    // Result returned to execute.
    typedef struct packed {
        logic  dcache_ok;
        word_t mem_result;
    } ms_to_es_t;

endpackage

`default_nettype wire

//--- rtl/dcache_pkg.sv
`default_nettype none

// Types on the data RAM side of the address unit.
package dcache_pkg;

    typedef logic [29:0] word_addr_t;   // Byte address bits 31:2.
    typedef logic [31:0] data_t;
    typedef logic [3:0]  byte_en_t;

    typedef struct packed {
        logic       valid;
        logic       we;
        word_addr_t addr;
        byte_en_t   be;
        data_t      wdata;   // Already steered into byte lanes.
    } ram_req_t;

    // Answer to the request of the previous cycle.
    typedef struct packed {
        logic  ok;
        data_t rdata;
    } ram_rsp_t;

endpackage

`default_nettype wire

//--- rtl/agu.sv
`timescale 1ns/1ps
`default_nettype none

module agu (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire mem_stage_pkg::addr_t     mem_addr,
    input  wire logic                     is_unsigned,
    input  wire logic                     mem_we,
    input  wire logic                     mem_rd,
    input  wire mem_stage_pkg::size_t     bit_width,
    input  wire mem_stage_pkg::word_t     wdata,
    output dcache_pkg::ram_req_t          ram_req,
    input  wire dcache_pkg::ram_rsp_t     ram_rsp,
    output mem_stage_pkg::ms_to_es_t      result,
    output logic                          excp_ale
);

    logic [1:0]           off;
    logic                 access;
    logic                 misalign;
    dcache_pkg::byte_en_t be;

    // Attributes of the access now in flight.
    logic [1:0]           off_q;
    mem_stage_pkg::size_t size_q;
    logic                 unsigned_q;
    logic                 rd_q;
    logic                 ale_q;

    mem_stage_pkg::word_t lane_data;
    mem_stage_pkg::word_t load_val;

    assign off    = mem_addr[1:0];
    assign access = mem_we | mem_rd;

    // Natural alignment.
    always_comb
    begin
        case (bit_width)
            mem_stage_pkg::SIZE_HALF: misalign = off[0];
            mem_stage_pkg::SIZE_WORD: misalign = |off;
            default:                  misalign = 1'b0;
        endcase
    end

    always_comb
    begin
        case (bit_width)
            mem_stage_pkg::SIZE_BYTE: be = 4'b0001 << off;
            mem_stage_pkg::SIZE_HALF: be = 4'b0011 << off;
            mem_stage_pkg::SIZE_WORD: be = 4'b1111;
            default:                  be = 4'b0000;
        endcase
    end

    // Misaligned accesses never reach the RAM.
    assign ram_req = '{
        valid: access & ~misalign,
        we:    mem_we,
        addr:  mem_addr[31:2],
        be:    be,
        wdata: wdata << {off, 3'b000}
    };

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_q  <= 1'b0;
            ale_q <= 1'b0;
        end
        else
        begin
            rd_q  <= mem_rd & ~misalign;
            ale_q <= access & misalign;
        end
    end

    always_ff @(posedge clk)
    begin
        off_q      <= off;
        size_q     <= bit_width;
        unsigned_q <= is_unsigned;
    end

    assign lane_data = ram_rsp.rdata >> {off_q, 3'b000};   // Addressed byte to bit 0.

    always_comb
    begin
        case (size_q)
            mem_stage_pkg::SIZE_BYTE:
                load_val = {{24{lane_data[7] & ~unsigned_q}}, lane_data[7:0]};
            mem_stage_pkg::SIZE_HALF:
                load_val = {{16{lane_data[15] & ~unsigned_q}}, lane_data[15:0]};
            default:
                load_val = lane_data;
        endcase
    end

    assign result = '{
        dcache_ok:  ram_rsp.ok,
        mem_result: rd_q ? load_val : '0   // Stores return zero.
    };
    assign excp_ale = ale_q;

    // RAM answers exactly one cycle after each request.
    a_rsp_follows_req: assert property (@(posedge clk) disable iff (rst)
        ram_req.valid |=> ram_rsp.ok);
    a_rsp_only_after_req: assert property (@(posedge clk) disable iff (rst)
        ram_rsp.ok |-> $past(ram_req.valid));

    a_ale_ok_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(excp_ale && ram_rsp.ok));

endmodule

`default_nettype wire

//--- rtl/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire dcache_pkg::ram_req_t req,
    output dcache_pkg::ram_rsp_t      rsp
);

    localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    dcache_pkg::data_t mem [RAM_WORDS];
    logic [AW-1:0]     idx;
    logic              ok_q;
    dcache_pkg::data_t rdata_q;

    assign idx = req.addr[AW-1:0];

    // Contents cleared by reset, so keep RAM_WORDS small.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < RAM_WORDS; i++)
                mem[i] <= '0;
        end
        else if (req.valid && req.we)
        begin
            for (int b = 0; b < 4; b++)
                if (req.be[b])
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
    end

    always_ff @(posedge clk)
    begin
        if (req.valid && !req.we)
            rdata_q <= mem[idx];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            ok_q <= 1'b0;
        else
            ok_q <= req.valid;   // Every request answered next edge.
    end

    assign rsp = '{ok: ok_q, rdata: rdata_q};

    a_addr_in_range: assert property (@(posedge clk) disable iff (rst)
        req.valid |-> (req.addr < RAM_WORDS));

endmodule

`default_nettype wire

//--- rtl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire mem_stage_pkg::es_to_ms_t es_to_ms_bus1,
    input  wire mem_stage_pkg::es_to_ms_t es_to_ms_bus2,
    input  wire logic                     flush,
    output mem_stage_pkg::ms_to_es_t      ms_to_es_bus,
    output logic                          excp_ale,
    output dcache_pkg::ram_req_t          ram_req,
    input  wire dcache_pkg::ram_rsp_t     ram_rsp
);

    mem_stage_pkg::es_to_ms_t lane;   // Chosen micro-op, pc included.
    logic                     mem_we;
    logic                     mem_rd;

    // Lane 1 has priority when it holds a load or store.
    always_comb
    begin
        if (es_to_ms_bus1.mem_we || es_to_ms_bus1.mem_rd)
        begin
            lane = es_to_ms_bus1;
        end
        else
        begin
            lane = es_to_ms_bus2;
        end
    end

    // Flush cancels the access.
    assign mem_we = lane.mem_we & ~flush;
    assign mem_rd = lane.mem_rd & ~flush;

    agu u_agu (
        .clk         (clk),
        .rst         (rst),
        .mem_addr    (lane.mem_addr),
        .is_unsigned (lane.is_unsigned),
        .mem_we      (mem_we),
        .mem_rd      (mem_rd),
        .bit_width   (lane.bit_width),
        .wdata       (lane.wdata),
        .ram_req     (ram_req),
        .ram_rsp     (ram_rsp),
        .result      (ms_to_es_bus),
        .excp_ale    (excp_ale)
    );

endmodule

`default_nettype wire

//--- rtl/mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys #(
    parameter int RAM_WORDS = 256
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire mem_stage_pkg::es_to_ms_t es_to_ms_bus1,
    input  wire mem_stage_pkg::es_to_ms_t es_to_ms_bus2,
    input  wire logic                     flush,
    output mem_stage_pkg::ms_to_es_t      ms_to_es_bus,
    output logic                          excp_ale
);

    dcache_pkg::ram_req_t ram_req;
    dcache_pkg::ram_rsp_t ram_rsp;

    mem_stage u_mem_stage (
        .clk           (clk),
        .rst           (rst),
        .es_to_ms_bus1 (es_to_ms_bus1),
        .es_to_ms_bus2 (es_to_ms_bus2),
        .flush         (flush),
        .ms_to_es_bus  (ms_to_es_bus),
        .excp_ale      (excp_ale),
        .ram_req       (ram_req),
        .ram_rsp       (ram_rsp)
    );

    // Stands in for the dcache.
    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_data_ram (
        .clk (clk),
        .rst (rst),
        .req (ram_req),
        .rsp (ram_rsp)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD = 10,
    parameter int RST_CYCLES  = 3
) (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever
            #HALF_PERIOD clk = ~clk;
    end

    // Released just after an edge, like the other inputs.
    initial
    begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

    localparam int RAM_WORDS      = 256;
    localparam int STIM_MAX       = 64;   // Upper bound on stimulus lines.
    localparam int SWEEP_PAIRS    = 32;
    localparam int TIMEOUT_CYCLES = STIM_MAX + 2 * SWEEP_PAIRS + 20;

    typedef struct packed {
        logic                     ale;
        mem_stage_pkg::ms_to_es_t res;
    } expect_t;

    logic                     clk;
    logic                     rst;
    mem_stage_pkg::es_to_ms_t es_to_ms_bus1;
    mem_stage_pkg::es_to_ms_t es_to_ms_bus2;
    logic                     flush;
    mem_stage_pkg::ms_to_es_t ms_to_es_bus;
    logic                     excp_ale;

    expect_t            exp_q[$];
    logic [7:0]         shadow [RAM_WORDS * 4];   // Byte image of the RAM.
    int                 errors = 0;
    int                 checks = 0;
    int                 cycles = 0;
    int                 stim_lines = 0;
    logic [31:0]        rand_state = 32'd32194;
    mem_stage_pkg::pc_t pc_next = 32'h1c00_0000;

    // Fields of one stimulus line.
    int                       fd;
    int                       n;
    string                    line;
    logic                     we1, rd1, uns1, we2, rd2, uns2, fl, eok, eale;
    mem_stage_pkg::size_t     sz1, sz2;
    mem_stage_pkg::addr_t     a1, a2;
    mem_stage_pkg::word_t     d1, d2, eres;

    // Sweep state.
    mem_stage_pkg::size_t     sz;
    mem_stage_pkg::addr_t     a;
    mem_stage_pkg::word_t     d;
    logic                     on_lane2;
    logic                     uns;
    mem_stage_pkg::es_to_ms_t op;
    mem_stage_pkg::es_to_ms_t other;
    mem_stage_pkg::es_to_ms_t idle;
    mem_stage_pkg::ms_to_es_t exp_res;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    mem_subsys #(
        .RAM_WORDS (RAM_WORDS)
    ) mem_subsys_i (
        .clk           (clk),
        .rst           (rst),
        .es_to_ms_bus1 (es_to_ms_bus1),
        .es_to_ms_bus2 (es_to_ms_bus2),
        .flush         (flush),
        .ms_to_es_bus  (ms_to_es_bus),
        .excp_ale      (excp_ale)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic mem_stage_pkg::es_to_ms_t make_op(
        input logic we, input logic rd, input logic u, input mem_stage_pkg::size_t size,
        input mem_stage_pkg::addr_t addr, input mem_stage_pkg::word_t data);
        mem_stage_pkg::es_to_ms_t m;
        m.mem_addr    = addr;
        m.is_unsigned = u;
        m.mem_we      = we;
        m.mem_rd      = rd;
        m.bit_width   = size;
        m.wdata       = data;
        m.pc          = pc_next;
        return m;
    endfunction

    function automatic void model_store(input mem_stage_pkg::addr_t addr,
        input mem_stage_pkg::size_t size, input mem_stage_pkg::word_t data);
        for (int i = 0; i < int'(size); i++)
            shadow[int'(addr) + i] = data[8*i +: 8];
    endfunction

    // Little-endian gather, then sign or zero fill above the loaded bytes.
    function automatic mem_stage_pkg::word_t model_load(input mem_stage_pkg::addr_t addr,
        input mem_stage_pkg::size_t size, input logic u);
        mem_stage_pkg::word_t v;
        logic                 fill;
        v = '0;
        for (int i = 0; i < int'(size); i++)
            v[8*i +: 8] = shadow[int'(addr) + i];
        fill = ~u & v[8*int'(size) - 1];
        for (int i = 8 * int'(size); i < 32; i++)
            v[i] = fill;
        return v;
    endfunction

    task automatic check_result(input mem_stage_pkg::ms_to_es_t want,
        input mem_stage_pkg::ms_to_es_t got);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("** Error at %0t: ms_to_es_bus expected ok=%b result=%h, got ok=%b result=%h",
                $time, want.dcache_ok, want.mem_result, got.dcache_ok, got.mem_result);
        end
    endtask

    task automatic check_ale(input logic want, input logic got);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("** Error at %0t: excp_ale expected %b, got %b", $time, want, got);
        end
    endtask

    task automatic check_pending();
        expect_t e;
        if (exp_q.size() > 0)
        begin
            e = exp_q.pop_front();
            check_result(e.res, ms_to_es_bus);
            check_ale(e.ale, excp_ale);
        end
    endtask

    // Outputs of the last cycle are checked before new inputs go out.
    task automatic drive_cycle(input mem_stage_pkg::es_to_ms_t op1,
        input mem_stage_pkg::es_to_ms_t op2, input logic fl_in,
        input mem_stage_pkg::ms_to_es_t want_res, input logic want_ale);
        expect_t e;
        @(posedge clk);
        #1;
        check_pending();
        #1;
        es_to_ms_bus1 = op1;
        es_to_ms_bus2 = op2;
        flush         = fl_in;
        pc_next       = pc_next + 32'd4;
        e.res = want_res;
        e.ale = want_ale;
        exp_q.push_back(e);
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial
    begin
        es_to_ms_bus1 = '0;
        es_to_ms_bus2 = '0;
        flush         = 1'b0;
        idle          = '0;
        for (int i = 0; i < RAM_WORDS * 4; i++)
            shadow[i] = 8'h00;
        fd = $fopen("bench/mem_stim.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open bench/mem_stim.txt, the directed tests did not run.");
            errors++;
        end

        @(posedge clk);
        while (rst)
            @(posedge clk);
        #1;
        exp_res = '0;   // Outputs quiet after reset.
        check_result(exp_res, ms_to_es_bus);
        check_ale(1'b0, excp_ale);

        if (fd != 0)
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() > 1 && line.getc(0) != 8'h23)   // Skip comment lines.
                begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        we1, rd1, uns1, sz1, a1, d1, we2, rd2, uns2, sz2, a2, d2,
                        fl, eok, eale, eres);
                    if (n != 16)
                    begin
                        $display("Stimulus line could not be parsed: %0s", line);
                        errors++;
                    end
                    else
                    begin
                        exp_res.dcache_ok  = eok;
                        exp_res.mem_result = eres;
                        drive_cycle(make_op(we1, rd1, uns1, sz1, a1, d1),
                            make_op(we2, rd2, uns2, sz2, a2, d2), fl, exp_res, eale);
                        stim_lines++;
                    end
                end
            end
            $fclose(fd);
            if (stim_lines == 0)
            begin
                $display("The stimulus file held no test lines.");
                errors++;
            end
        end

        // Random store then load pairs in the upper half of the RAM.
        for (int p = 0; p < SWEEP_PAIRS; p++)
        begin
            rand_state = lcg_next(rand_state);
            case (rand_state[17:16])
                2'd0:    sz = mem_stage_pkg::SIZE_BYTE;
                2'd1:    sz = mem_stage_pkg::SIZE_HALF;
                default: sz = mem_stage_pkg::SIZE_WORD;
            endcase
            a = 32'h200 + {23'd0, rand_state[24:18], 2'b00};
            if (sz == mem_stage_pkg::SIZE_BYTE)
                a[1:0] = rand_state[26:25];
            else if (sz == mem_stage_pkg::SIZE_HALF)
                a[1:0] = {rand_state[26], 1'b0};
            on_lane2   = rand_state[30];
            rand_state = lcg_next(rand_state);
            d          = rand_state;
            uns        = rand_state[31];

            op      = make_op(1'b1, 1'b0, 1'b0, sz, a, d);
            other   = make_op(1'b1, 1'b0, 1'b0, mem_stage_pkg::SIZE_WORD, {a[31:2], 2'b00}, ~d);
            exp_res = '{dcache_ok: 1'b1, mem_result: '0};
            if (on_lane2)
                drive_cycle(idle, op, 1'b0, exp_res, 1'b0);
            else
                drive_cycle(op, other, 1'b0, exp_res, 1'b0);   // Lane 2 store is dropped.
            model_store(a, sz, d);

            op                 = make_op(1'b0, 1'b1, uns, sz, a, '0);
            exp_res.mem_result = model_load(a, sz, uns);
            if (on_lane2)
                drive_cycle(idle, op, 1'b0, exp_res, 1'b0);
            else
                drive_cycle(op, other, 1'b0, exp_res, 1'b0);
        end

        @(posedge clk);
        #1;
        check_pending();
        $display("%0d stimulus lines, %0d sweep pairs, %0d checks, %0d errors",
            stim_lines, SWEEP_PAIRS, checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/mem_stim.txt
# we1 rd1 uns1 size1 addr1 wdata1  we2 rd2 uns2 size2 addr2 wdata2  flush  ok ale result
# Hex fields, one cycle per line; ok, ale and result are expected on the next cycle.
0 1 0 4 00000000 00000000  0 0 0 0 00000000 00000000  0  1 0 00000000
0 1 1 1 0000003d 00000000  0 0 0 0 00000000 00000000  0  1 0 00000000
0 0 0 0 00000000 00000000  0 1 0 2 00000022 00000000  0  1 0 00000000
1 0 0 4 00000004 8badf00d  0 0 0 0 00000000 00000000  0  1 0 00000000
0 1 0 4 00000004 00000000  0 0 0 0 00000000 00000000  0  1 0 8badf00d
0 1 0 1 00000005 00000000  0 0 0 0 00000000 00000000  0  1 0 fffffff0
0 1 1 1 00000005 00000000  0 0 0 0 00000000 00000000  0  1 0 000000f0
0 1 0 1 00000004 00000000  0 0 0 0 00000000 00000000  0  1 0 0000000d
0 1 0 1 00000007 00000000  0 0 0 0 00000000 00000000  0  1 0 ffffff8b
0 1 1 1 00000006 00000000  0 0 0 0 00000000 00000000  0  1 0 000000ad
0 1 0 2 00000006 00000000  0 0 0 0 00000000 00000000  0  1 0 ffff8bad
0 1 1 2 00000004 00000000  0 0 0 0 00000000 00000000  0  1 0 0000f00d
0 1 0 2 00000004 00000000  0 0 0 0 00000000 00000000  0  1 0 fffff00d
1 0 0 1 00000008 00000011  0 0 0 0 00000000 00000000  0  1 0 00000000
1 0 0 1 00000009 aaaaaa82  0 0 0 0 00000000 00000000  0  1 0 00000000
1 0 0 1 0000000a 00000033  0 0 0 0 00000000 00000000  0  1 0 00000000
1 0 0 1 0000000b ffffffc4  0 0 0 0 00000000 00000000  0  1 0 00000000
0 1 0 4 00000008 00000000  0 0 0 0 00000000 00000000  0  1 0 c4338211
0 1 0 1 00000009 00000000  0 0 0 0 00000000 00000000  0  1 0 ffffff82
0 1 1 2 0000000a 00000000  0 0 0 0 00000000 00000000  0  1 0 0000c433
1 0 0 2 0000000c 12347fff  0 0 0 0 00000000 00000000  0  1 0 00000000
1 0 0 2 0000000e 0000beef  0 0 0 0 00000000 00000000  0  1 0 00000000
0 1 0 4 0000000c 00000000  0 0 0 0 00000000 00000000  0  1 0 beef7fff
0 1 0 2 0000000c 00000000  0 0 0 0 00000000 00000000  0  1 0 00007fff
0 1 0 2 0000000e 00000000  0 0 0 0 00000000 00000000  0  1 0 ffffbeef
0 1 1 2 0000000e 00000000  0 0 0 0 00000000 00000000  0  1 0 0000beef
1 0 0 4 00000010 01020304  0 0 0 0 00000000 00000000  0  1 0 00000000
0 1 0 4 00000010 00000000  0 0 0 0 00000000 00000000  0  1 0 01020304
1 0 0 1 00000011 000000ff  0 0 0 0 00000000 00000000  0  1 0 00000000
0 1 1 1 00000011 00000000  0 0 0 0 00000000 00000000  0  1 0 000000ff
1 0 0 4 00000014 cafebabe  0 0 0 0 00000000 00000000  0  1 0 00000000
0 0 0 0 00000000 00000000  1 0 0 4 00000018 0badcafe  0  1 0 00000000
0 1 0 4 00000014 00000000  0 0 0 0 00000000 00000000  0  1 0 cafebabe
0 1 0 4 00000018 00000000  0 0 0 0 00000000 00000000  0  1 0 0badcafe
0 1 0 4 00000010 00000000  0 0 0 0 00000000 00000000  0  1 0 0102ff04
1 0 0 4 0000001c deadbeef  1 0 0 4 00000020 55555555  0  1 0 00000000
0 1 0 4 0000001c 00000000  0 0 0 0 00000000 00000000  0  1 0 deadbeef
0 1 0 4 00000020 00000000  0 0 0 0 00000000 00000000  0  1 0 00000000
0 0 0 0 00000000 00000000  1 0 0 4 00000020 12345678  0  1 0 00000000
0 1 0 4 0000001c 00000000  0 1 0 4 00000020 00000000  0  1 0 deadbeef
0 0 0 0 00000000 00000000  0 1 0 4 00000020 00000000  0  1 0 12345678
0 1 1 1 0000001f 00000000  1 0 0 4 0000001c 00000000  0  1 0 000000de
0 1 0 4 0000001c 00000000  0 0 0 0 00000000 00000000  0  1 0 deadbeef
1 0 0 4 00000025 ffffffff  0 0 0 0 00000000 00000000  0  0 1 00000000
0 1 0 4 00000024 00000000  0 0 0 0 00000000 00000000  0  1 0 00000000
1 0 0 2 00000027 0000ffff  0 0 0 0 00000000 00000000  0  0 1 00000000
0 1 0 2 00000025 00000000  0 0 0 0 00000000 00000000  0  0 1 00000000
0 1 0 4 00000026 00000000  0 0 0 0 00000000 00000000  0  0 1 00000000
0 1 0 4 00000024 00000000  0 0 0 0 00000000 00000000  0  1 0 00000000
0 0 0 0 00000000 00000000  1 0 0 2 00000013 0000aaaa  0  0 1 00000000
0 1 0 4 00000010 00000000  0 0 0 0 00000000 00000000  0  1 0 0102ff04
1 0 0 4 00000021 11111111  1 0 0 4 00000024 22222222  0  0 1 00000000
1 0 0 4 00000024 77777777  0 0 0 0 00000000 00000000  1  0 0 00000000
0 1 0 4 00000004 00000000  0 0 0 0 00000000 00000000  1  0 0 00000000
1 0 0 4 00000027 33333333  0 0 0 0 00000000 00000000  1  0 0 00000000
0 1 0 4 00000024 00000000  0 0 0 0 00000000 00000000  0  1 0 00000000
0 0 0 0 00000000 00000000  1 0 0 4 00000028 0000abcd  1  0 0 00000000
0 1 0 4 00000028 00000000  0 0 0 0 00000000 00000000  0  1 0 00000000
0 1 0 4 00000004 00000000  0 0 0 0 00000000 00000000  0  1 0 8badf00d

//--- sim.f
rtl/mem_stage_pkg.sv
rtl/dcache_pkg.sv
rtl/agu.sv
rtl/data_ram.sv
rtl/mem_stage.sv
rtl/mem_subsys.sv
bench/tb_clock.sv
bench/tb_mem_subsys.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_subsys -f sim.f -o tb_mem_subsys > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_mem_subsys > sim.log 2>&1 \
    || echo "Simulation exited with an error status" >> sim.log

grep -q '\*\*\* TEST FAILED \*\*\*' sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q '\*\*\* TEST PASSED \*\*\*' sim.log || { echo "No result in sim.log"; exit 1; }

echo "Simulation passed"
exit 0
